// ==== tb.f ====
rtl/bru_pkg.sv
rtl/bru_decode.sv
rtl/bru_operand_fwd.sv
rtl/bru_target.sv
rtl/bru_resolve.sv
rtl/bru_pipe.sv
testbench/tb_bru_pipe.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the branch pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f tb.f --top-module tb_bru_pipe -o sim_bru > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_bru > sim.log 2>&1 || true

grep -q "ALL TESTS PASSED" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== testbench/tb_bru_pipe.sv ====
`timescale 1ns/100ps

module tb_bru_pipe import bru_pkg::*; ();

  typedef struct {
    string      name;
    int         kind;     // 0 branch, 1 JAL, 2 JALR
    logic [2:0] f3;
    xlen_t      pc;
    int         off;
    rnid_t      s1;
    rnid_t      s2;
    logic [4:0] rd;
    rnid_t      rd_tag;
    logic       btb;
    logic       pt;
    xlen_t      ptgt;
    int         fwd;      // 0 none, 1 ex1, 2 ex2
    rnid_t      ftag;
    int         gap;
  } row_t;

  logic    i_clk = 1'b0;
  logic    i_reset_n;
  issue_t  i_issue;
  rd_req_t o_rd_req;
  xlen_t   i_rd_data1;
  xlen_t   i_rd_data2;
  phy_wr_t i_wr_bus [NUM_WR_BUS];
  phy_wr_t o_link_wr;
  br_upd_t o_br_upd;
  done_t   o_done;

  xlen_t   rf [64];
  row_t    rows [$];
  br_upd_t exp_upd [$];
  phy_wr_t exp_wr [$];
  done_t   exp_done [$];
  int      exp_cyc [$];
  string   exp_name [$];
  int      cyc = 0;
  int      err_count = 0;
  int      pass_count = 0;

  bru_pipe UUT (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_issue    (i_issue),
    .o_rd_req   (o_rd_req),
    .i_rd_data1 (i_rd_data1),
    .i_rd_data2 (i_rd_data2),
    .i_wr_bus   (i_wr_bus),
    .o_link_wr  (o_link_wr),
    .o_br_upd   (o_br_upd),
    .o_done     (o_done)
  );

  always #20 i_clk = ~i_clk;
  always @(posedge i_clk) cyc <= cyc + 1;

  // Register file answers at once, garbage unless the port is valid
  assign i_rd_data1 = o_rd_req.src1.valid ? rf[o_rd_req.src1.tag] : ~rf[o_rd_req.src1.tag];
  assign i_rd_data2 = o_rd_req.src2.valid ? rf[o_rd_req.src2.tag] : ~rf[o_rd_req.src2.tag];

  function automatic xlen_t bus_val(input rnid_t tag);
    return rf[tag] ^ 32'ha5a5_0f0f;   // Never equal to the register value
  endfunction

  function automatic xlen_t operand(input row_t r, input rnid_t tag);
    if (r.fwd != 0 && r.ftag == tag && tag != '0)
      return bus_val(tag);
    return rf[tag];
  endfunction

  function automatic logic [31:0] encode(input row_t r);
    logic [31:0] o;
    o = r.off;
    case (r.kind)
      1:       return {o[20], o[10:1], o[11], o[19:12], r.rd, 7'b1101111};
      2:       return {o[11:0], r.s1[4:0], 3'b000, r.rd, 7'b1100111};
      default: return {o[12], o[10:5], r.s2[4:0], r.s1[4:0], r.f3, o[4:1], o[11], 7'b1100011};
    endcase
  endfunction

  task automatic add_row(input string name, input int kind, input logic [2:0] f3,
                         input xlen_t pc, input int off, input int s1, input int s2,
                         input logic [4:0] rd, input logic btb, input logic pt,
                         input xlen_t ptgt, input int fwd, input int ftag, input int gap);
    row_t r;
    r = '{name, kind, f3, pc, off, rnid_t'(s1), rnid_t'(s2), rd, rnid_t'(s1 + 20),
          btb, pt, ptgt, fwd, rnid_t'(ftag), gap};
    rows.push_back(r);
  endtask

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  task automatic expect_row(input row_t r, input int idx, input int issue_cyc);
    xlen_t   a;
    xlen_t   b;
    xlen_t   tgt;
    logic    taken;
    br_upd_t u;
    phy_wr_t w;
    done_t   d;
    a = operand(r, r.s1);
    b = operand(r, r.s2);
    tgt = r.pc + xlen_t'(r.off);
    taken = 1'b1;
    if (r.kind == 0) begin
      case (r.f3)
        3'd0:    taken = a == b;
        3'd1:    taken = a != b;
        3'd4:    taken = $signed(a) < $signed(b);
        3'd5:    taken = $signed(a) >= $signed(b);
        3'd6:    taken = a < b;
        default: taken = a >= b;
      endcase
    end else if (r.kind == 2) begin
      tgt = (a + xlen_t'(r.off)) & ~xlen_t'(1);
    end
    u.valid = 1'b1;
    u.is_cond = r.kind == 0;
    u.taken = taken;
    if (r.btb)
      u.mispredict = !((!taken && !r.pt) || (taken && r.pt && tgt == r.ptgt));
    else
      u.mispredict = taken;
    u.pc = r.pc;
    u.target = taken ? tgt : r.pc + 32'd4;
    w.valid = r.kind != 0 && r.rd != 5'd0;
    w.tag = r.rd_tag;
    w.data = r.pc + 32'd4;
    d.valid = 1'b1;
    d.cmt_id = idx[CMT_ID_W-1:0];
    exp_upd.push_back(u);
    exp_wr.push_back(w);
    exp_done.push_back(d);
    exp_cyc.push_back(issue_cyc + 4);
    exp_name.push_back(r.name);
  endtask

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_upd(input string name, input br_upd_t exp, input br_upd_t act);
    if (exp !== act) begin
      $display("ERROR %s upd expected %h actual %h", name, exp, act);
      err_count++;
    end else begin
      $display("ok    %s upd %h", name, act);
      pass_count++;
    end
  endtask

  task automatic check_wr(input string name, input phy_wr_t exp, input phy_wr_t act);
    if (exp !== act) begin
      $display("ERROR %s link expected %h actual %h", name, exp, act);
      err_count++;
    end else begin
      $display("ok    %s link %h", name, act);
      pass_count++;
    end
  endtask

  task automatic check_done(input string name, input done_t exp, input done_t act);
    if (exp !== act) begin
      $display("ERROR %s done expected %h actual %h", name, exp, act);
      err_count++;
    end else begin
      $display("ok    %s done %h", name, act);
      pass_count++;
    end
  endtask

  task automatic check_idle(input string when);
    if (o_rd_req.src1.valid || o_rd_req.src2.valid || o_link_wr.valid ||
        o_br_upd.valid || o_done.valid) begin
      $display("An output valid was set %s", when);
      err_count++;
    end
  endtask

  task automatic drive_bus(input row_t r, input int stage, input int idx);
    for (int i = 0; i < NUM_WR_BUS; i++)
      i_wr_bus[i] <= '0;
    if (r.fwd != 0 && r.fwd == stage)
      i_wr_bus[idx % NUM_WR_BUS] <= '{1'b1, r.ftag, bus_val(r.ftag)};
  endtask

  task automatic run_stimulus();
    row_t r;
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      @(posedge i_clk);
      i_issue <= '{1'b1, encode(r), r.pc, '{1'b1, r.s1}, '{1'b1, r.s2}, r.rd_tag,
                   i[CMT_ID_W-1:0], r.btb, r.pt, r.ptgt};
      drive_bus(r, 0, i);
      expect_row(r, i, cyc);
      for (int c = 1; c <= r.gap; c++) begin
        @(posedge i_clk);
        i_issue.valid <= 1'b0;
        drive_bus(r, c, i);
      end
    end
    @(posedge i_clk);
    i_issue.valid <= 1'b0;
    drive_bus(rows[0], 0, 0);
  endtask

  task automatic run_checker();
    int waited;
    for (int n = 0; n < rows.size(); n++) begin
      waited = 0;
      @(negedge i_clk);
      while (!o_done.valid && waited < 12) begin
        @(negedge i_clk);
        waited++;
      end
      if (!o_done.valid) begin
        $display("Timed out waiting for the done report of %s", exp_name[0]);
        err_count++;
        break;
      end else begin
        if (cyc != exp_cyc[0]) begin
          $display("%s reported at cycle %0d, not %0d", exp_name[0], cyc, exp_cyc[0]);
          err_count++;
        end
        check_upd(exp_name[0], exp_upd.pop_front(), o_br_upd);
        check_wr(exp_name[0], exp_wr.pop_front(), o_link_wr);
        check_done(exp_name[0], exp_done.pop_front(), o_done);
        void'(exp_cyc.pop_front());
        void'(exp_name.pop_front());
      end
    end
  endtask

  initial begin
    logic [31:0] rnd;
    void'($urandom(46));
    i_reset_n = 1'b0;
    i_issue = '0;
    for (int i = 0; i < NUM_WR_BUS; i++)
      i_wr_bus[i] = '0;
    for (int i = 0; i < 64; i++)
      rf[i] = $urandom;
    rf[0] = '0;
    rf[1] = 32'hffff_fff0;   // Negative against small positive
    rf[2] = 32'h0000_0010;
    rf[3] = 32'h0000_0010;
    rf[4] = 32'h0000_1003;
    rf[6] = 32'h55;
    rf[7] = 32'h55;
    rf[8] = '0;

    add_row("beq_taken", 0, 3'd0, 32'h1000, 64, 2, 3, 0, 0, 0, 0, 0, 0, 3);
    add_row("bne_not", 0, 3'd1, 32'h1100, 64, 2, 3, 0, 0, 0, 0, 0, 0, 3);
    add_row("blt_neg", 0, 3'd4, 32'h1200, 256, 1, 2, 0, 0, 0, 0, 0, 0, 3);
    add_row("bge_neg", 0, 3'd5, 32'h1300, 256, 1, 2, 0, 0, 0, 0, 0, 0, 3);
    add_row("bltu_neg", 0, 3'd6, 32'h1400, 256, 1, 2, 0, 0, 0, 0, 0, 0, 3);
    add_row("bgeu_neg", 0, 3'd7, 32'h1500, -32, 1, 2, 0, 0, 0, 0, 0, 0, 3);
    add_row("jal_link", 1, 3'd0, 32'h2000, 2048, 5, 0, 5, 0, 0, 0, 0, 0, 3);
    add_row("jal_rd0", 1, 3'd0, 32'h2100, -4096, 5, 0, 0, 0, 0, 0, 0, 0, 3);
    add_row("jalr_link", 2, 3'd0, 32'h2200, -2, 4, 0, 1, 0, 0, 0, 0, 0, 3);
    add_row("fwd_ex1", 0, 3'd0, 32'h3000, 16, 6, 7, 0, 0, 0, 0, 1, 6, 3);
    add_row("fwd_ex2", 0, 3'd0, 32'h3100, 16, 6, 7, 0, 0, 0, 0, 2, 7, 3);
    add_row("fwd_tag0", 0, 3'd0, 32'h3200, 16, 0, 8, 0, 0, 0, 0, 1, 0, 3);
    add_row("mp_pt_nt", 0, 3'd1, 32'h4000, 32, 2, 3, 0, 1, 1, 32'h4020, 0, 0, 3);
    add_row("mp_tt_ok", 0, 3'd0, 32'h4100, 32, 2, 3, 0, 1, 1, 32'h4120, 0, 0, 3);
    add_row("mp_tt_bad", 0, 3'd0, 32'h4200, 32, 2, 3, 0, 1, 1, 32'h4240, 0, 0, 3);
    add_row("mp_nn", 0, 3'd1, 32'h4300, 32, 2, 3, 0, 1, 0, 0, 0, 0, 3);
    add_row("mp_nt_tk", 0, 3'd0, 32'h4400, 32, 2, 3, 0, 1, 0, 0, 0, 0, 3);
    add_row("mp_no_btb", 0, 3'd1, 32'h4500, 32, 1, 2, 0, 0, 1, 32'h4520, 0, 0, 3);
    // Back-to-back burst with random operands and predictions
    for (int i = 0; i < 8; i++) begin
      rnd = $urandom;
      add_row($sformatf("burst_%0d", i), 0, rnd[2] ? {2'b11, rnd[0]} : {2'b00, rnd[0]},
              32'h5000 + 32'(i * 4), 64, 1 + int'(rnd[8:4]), 1 + int'(rnd[13:9]), 0,
              rnd[16], rnd[17], rnd[18] ? 32'h5040 + 32'(i * 4) : 32'h5004, 0, 0, 0);
    end

    for (int i = 0; i < 8; i++) begin
      @(negedge i_clk);
      check_idle("during reset");
    end
    @(posedge i_clk);
    i_reset_n <= 1'b1;
    for (int i = 0; i < 2; i++) begin
      @(negedge i_clk);
      check_idle("just after reset");
    end

    fork
      run_stimulus();
      run_checker();
    join

    $display("%0d checks passed, %0d errors", pass_count, err_count);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/bru_pipe.sv ====
`timescale 1ns/100ps

module bru_pipe import bru_pkg::*; (
  input  logic    i_clk,
  input  logic    i_reset_n,
  input  issue_t  i_issue,
  output rd_req_t o_rd_req,
  input  xlen_t   i_rd_data1,
  input  xlen_t   i_rd_data2,
  input  phy_wr_t i_wr_bus [NUM_WR_BUS],
  output phy_wr_t o_link_wr,
  output br_upd_t o_br_upd,
  output done_t   o_done
);

  pipe_ctrl_t w_ex0_ctrl;

  issue_t     r_ex1_issue;
  pipe_ctrl_t r_ex1_ctrl;
  logic       w_ex1_hit1;
  logic       w_ex1_hit2;
  xlen_t      w_ex1_fwd1;
  xlen_t      w_ex1_fwd2;

  issue_t     r_ex2_issue;
  pipe_ctrl_t r_ex2_ctrl;
  xlen_t      r_ex2_rs1;
  xlen_t      r_ex2_rs2;
  logic       w_ex2_hit1;
  logic       w_ex2_hit2;
  xlen_t      w_ex2_fwd1;
  xlen_t      w_ex2_fwd2;
  xlen_t      w_ex2_rs1;
  xlen_t      w_ex2_rs2;
  xlen_t      w_ex2_target;

  // --------------------------------------------------------------------------
  // ex0 decode
  // --------------------------------------------------------------------------
  bru_decode u_decode (
    .i_inst (i_issue.inst),
    .o_ctrl (w_ex0_ctrl)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
      r_ex2_issue <= '0;
      r_ex2_ctrl  <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_ctrl  <= w_ex0_ctrl;
      r_ex2_issue <= r_ex1_issue;
      r_ex2_ctrl  <= r_ex1_ctrl;
    end
  end

  // --------------------------------------------------------------------------
  // ex1 register read and first forwarding point
  // --------------------------------------------------------------------------
  assign o_rd_req.src1.valid = r_ex1_issue.valid & r_ex1_issue.src1.valid;
  assign o_rd_req.src1.tag   = r_ex1_issue.src1.tag;
  assign o_rd_req.src2.valid = r_ex1_issue.valid & r_ex1_issue.src2.valid;
  assign o_rd_req.src2.tag   = r_ex1_issue.src2.tag;

  bru_operand_fwd u_ex1_fwd1 (
    .i_src    (r_ex1_issue.src1),
    .i_wr_bus (i_wr_bus),
    .o_hit    (w_ex1_hit1),
    .o_data   (w_ex1_fwd1)
  );

  bru_operand_fwd u_ex1_fwd2 (
    .i_src    (r_ex1_issue.src2),
    .i_wr_bus (i_wr_bus),
    .o_hit    (w_ex1_hit2),
    .o_data   (w_ex1_fwd2)
  );

  always_ff @(posedge i_clk) begin
    r_ex2_rs1 <= w_ex1_hit1 ? w_ex1_fwd1 : i_rd_data1;
    r_ex2_rs2 <= w_ex1_hit2 ? w_ex1_fwd2 : i_rd_data2;
  end

  // --------------------------------------------------------------------------
  // ex2 second forwarding point and target
  // --------------------------------------------------------------------------
  bru_operand_fwd u_ex2_fwd1 (
    .i_src    (r_ex2_issue.src1),
    .i_wr_bus (i_wr_bus),
    .o_hit    (w_ex2_hit1),
    .o_data   (w_ex2_fwd1)
  );

  bru_operand_fwd u_ex2_fwd2 (
    .i_src    (r_ex2_issue.src2),
    .i_wr_bus (i_wr_bus),
    .o_hit    (w_ex2_hit2),
    .o_data   (w_ex2_fwd2)
  );

  assign w_ex2_rs1 = w_ex2_hit1 ? w_ex2_fwd1 : r_ex2_rs1;   // Newer result wins
  assign w_ex2_rs2 = w_ex2_hit2 ? w_ex2_fwd2 : r_ex2_rs2;

  bru_target u_target (
    .i_inst   (r_ex2_issue.inst),
    .i_imm    (r_ex2_ctrl.imm),
    .i_pc     (r_ex2_issue.pc),
    .i_rs1    (w_ex2_rs1),
    .o_target (w_ex2_target)
  );

  bru_resolve u_resolve (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (r_ex2_issue),
    .i_ctrl    (r_ex2_ctrl),
    .i_rs1     (w_ex2_rs1),
    .i_rs2     (w_ex2_rs2),
    .i_target  (w_ex2_target),
    .o_link_wr (o_link_wr),
    .o_br_upd  (o_br_upd),
    .o_done    (o_done)
  );

endmodule

// ==== rtl/bru_resolve.sv ====
`timescale 1ns/100ps

module bru_resolve import bru_pkg::*; (
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  issue_t     i_issue,
  input  pipe_ctrl_t i_ctrl,
  input  xlen_t      i_rs1,
  input  xlen_t      i_rs2,
  input  xlen_t      i_target,
  output phy_wr_t    o_link_wr,
  output br_upd_t    o_br_upd,
  output done_t      o_done
);

  logic       w_taken;
  issue_t     r_issue;
  pipe_ctrl_t r_ctrl;
  logic       r_taken;
  xlen_t      r_target;
  xlen_t      w_next_pc;
  logic       w_pred_hit;

  always_comb begin
    case (i_ctrl.op)
      OP_EQ:   w_taken = i_rs1 == i_rs2;
      OP_NE:   w_taken = i_rs1 != i_rs2;
      OP_LT:   w_taken = $signed(i_rs1) <  $signed(i_rs2);
      OP_GE:   w_taken = $signed(i_rs1) >= $signed(i_rs2);
      OP_LTU:  w_taken = i_rs1 <  i_rs2;
      OP_GEU:  w_taken = i_rs1 >= i_rs2;
      default: w_taken = 1'b1;   // JAL / JALR
    endcase
  end

  // --------------------------------------------------------------------------
  // ex3 register
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_issue <= '0;
      r_ctrl  <= '0;
    end else begin
      r_issue <= i_issue;
      r_ctrl  <= i_ctrl;
    end
  end

  always_ff @(posedge i_clk) begin
    r_taken  <= w_taken;
    r_target <= i_target;
  end

  assign w_next_pc = r_issue.pc + XLEN'(4);

  // BTB guess was right: both not taken, or both taken to the same place
  assign w_pred_hit = (~r_taken & ~r_issue.pred_taken) |
                      (r_taken & r_issue.pred_taken & (r_target == r_issue.pred_target));

  assign o_br_upd.valid      = r_issue.valid;
  assign o_br_upd.is_cond    = r_ctrl.is_cond;
  assign o_br_upd.taken      = r_taken;
  assign o_br_upd.mispredict = r_issue.btb_valid ? ~w_pred_hit : r_taken;
  assign o_br_upd.pc         = r_issue.pc;
  assign o_br_upd.target     = r_taken ? r_target : w_next_pc;

  assign o_link_wr.valid = r_issue.valid & r_ctrl.wr_rd & (r_issue.inst.j_fmt.rd != '0);
  assign o_link_wr.tag   = r_issue.rd_tag;
  assign o_link_wr.data  = w_next_pc;

  assign o_done.valid  = r_issue.valid;
  assign o_done.cmt_id = r_issue.cmt_id;

endmodule

// ==== rtl/bru_target.sv ====
`timescale 1ns/100ps

module bru_target import bru_pkg::*; (
  input  inst_u i_inst,
  input  imm_t  i_imm,
  input  xlen_t i_pc,
  input  xlen_t i_rs1,
  output xlen_t o_target
);

  xlen_t w_off_sb;
  xlen_t w_off_uj;
  xlen_t w_off_i;
  xlen_t w_jalr_sum;

  assign w_off_sb = {{(XLEN-13){i_inst.b_fmt.imm12}},
                     i_inst.b_fmt.imm12,
                     i_inst.b_fmt.imm11,
                     i_inst.b_fmt.imm10_5,
                     i_inst.b_fmt.imm4_1,
                     1'b0};

  assign w_off_uj = {{(XLEN-21){i_inst.j_fmt.imm20}},
                     i_inst.j_fmt.imm20,
                     i_inst.j_fmt.imm19_12,
                     i_inst.j_fmt.imm11,
                     i_inst.j_fmt.imm10_1,
                     1'b0};

  assign w_off_i = {{(XLEN-12){i_inst.i_fmt.imm12[11]}}, i_inst.i_fmt.imm12};

  assign w_jalr_sum = i_rs1 + w_off_i;

  always_comb begin
    case (i_imm)
      IMM_SB:  o_target = i_pc + w_off_sb;
      IMM_UJ:  o_target = i_pc + w_off_uj;
      IMM_I:   o_target = {w_jalr_sum[XLEN-1:1], 1'b0};   // JALR drops bit 0
      default: o_target = i_pc;
    endcase
  end

endmodule

// ==== rtl/bru_operand_fwd.sv ====
`timescale 1ns/100ps

module bru_operand_fwd import bru_pkg::*; (
  input  src_t    i_src,
  input  phy_wr_t i_wr_bus [NUM_WR_BUS],
  output logic    o_hit,
  output xlen_t   o_data
);

  logic [NUM_WR_BUS-1:0] w_hit_vec;

  always_comb begin
    for (int i = 0; i < NUM_WR_BUS; i++) begin
      w_hit_vec[i] = i_src.valid & i_wr_bus[i].valid &
                     (i_src.tag == i_wr_bus[i].tag) &
                     (i_src.tag != '0);   // x0 never forwards
    end
  end

  // At most one bus carries a given tag, so OR of masked data is a one-hot mux
  always_comb begin
    o_data = '0;
    for (int i = 0; i < NUM_WR_BUS; i++) begin
      o_data = o_data | ({XLEN{w_hit_vec[i]}} & i_wr_bus[i].data);
    end
  end

  assign o_hit = |w_hit_vec;

endmodule

// ==== rtl/bru_decode.sv ====
`timescale 1ns/100ps

module bru_decode import bru_pkg::*; (
  input  inst_u      i_inst,
  output pipe_ctrl_t o_ctrl
);

  always_comb begin
    o_ctrl.op      = OP_EQ;
    o_ctrl.imm     = IMM_SB;
    o_ctrl.is_cond = 1'b0;
    o_ctrl.wr_rd   = 1'b0;

    case (i_inst.b_fmt.opcode)
      OPC_JAL: begin
        o_ctrl.op    = OP_JUMP;
        o_ctrl.imm   = IMM_UJ;
        o_ctrl.wr_rd = 1'b1;
      end
      OPC_JALR: begin
        o_ctrl.op    = OP_JUMP;
        o_ctrl.imm   = IMM_I;
        o_ctrl.wr_rd = 1'b1;
      end
      OPC_BRANCH: begin
        o_ctrl.imm     = IMM_SB;
        o_ctrl.is_cond = 1'b1;
        case (i_inst.b_fmt.funct3)
          F3_BEQ:  o_ctrl.op = OP_EQ;
          F3_BNE:  o_ctrl.op = OP_NE;
          F3_BLT:  o_ctrl.op = OP_LT;
          F3_BGE:  o_ctrl.op = OP_GE;
          F3_BLTU: o_ctrl.op = OP_LTU;
          F3_BGEU: o_ctrl.op = OP_GEU;
          default: o_ctrl.is_cond = 1'b0;   // Reserved funct3
        endcase
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== rtl/bru_pkg.sv ====
package bru_pkg;

  localparam int XLEN       = 32;
  localparam int RNID_W     = 6;
  localparam int CMT_ID_W   = 5;
  localparam int NUM_WR_BUS = 3;

  // Major opcodes handled by the branch unit
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [RNID_W-1:0] rnid_t;   // Tag 0 is the zero register

  typedef enum logic [2:0] {
    OP_EQ, OP_NE, OP_LT, OP_GE, OP_LTU, OP_GEU, OP_JUMP
  } op_t;

  typedef enum logic [1:0] {
    IMM_SB, IMM_UJ, IMM_I
  } imm_t;

  // --------------------------------------------------------------------------
  // Instruction word views
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
    i_fmt_t i_fmt;
  } inst_u;

  // --------------------------------------------------------------------------
  // Port bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    op_t  op;
    imm_t imm;
    logic is_cond;
    logic wr_rd;
  } pipe_ctrl_t;

  typedef struct packed {
    logic  valid;
    rnid_t tag;
  } src_t;

  typedef struct packed {
    logic                valid;
    inst_u               inst;
    xlen_t               pc;
    src_t                src1;
    src_t                src2;
    rnid_t               rd_tag;
    logic [CMT_ID_W-1:0] cmt_id;
    logic                btb_valid;
    logic                pred_taken;
    xlen_t               pred_target;
  } issue_t;

  typedef struct packed {
    src_t src1;
    src_t src2;
  } rd_req_t;

  typedef struct packed {
    logic  valid;
    rnid_t tag;
    xlen_t data;
  } phy_wr_t;

  typedef struct packed {
    logic  valid;
    logic  is_cond;
    logic  taken;
    logic  mispredict;
    xlen_t pc;
    xlen_t target;
  } br_upd_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
  } done_t;

endpackage
